// ==== sources.f ====
+incdir+hdl
hdl/bus_port_pkg.sv
hdl/obi_port_tracker.sv
hdl/sleep_unit.sv
hdl/core_bus_top.sv
test/tb_core_bus_top.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_core_bus_top
RTL_TOP  = core_bus_top
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== test/tb_core_bus_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bus_port_config.svh"

module tb_core_bus_top;

  // Random stimulus length
  // Timeout allows three times as much
  localparam int STIM_CYCLES = 1000;
  localparam int TIMEOUT     = 3 * STIM_CYCLES;
  localparam int MAX_OUT     = `BUS_MAX_OUTSTANDING;

  logic clk_i;
  logic rst_i;
  logic fetch_enable_i, wfi_i, fetch_enable_o, core_sleep_o;
  logic [31:0] irq_i, mie_i;
  logic if_req_i, if_ready_o, if_rvalid_o, if_err_o;
  logic [31:0] if_addr_i, if_rdata_o;
  logic lsu_req_i, lsu_we_i, lsu_ready_o, lsu_rvalid_o, lsu_err_o;
  logic [3:0] lsu_be_i;
  logic [31:0] lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic data_req_o, data_gnt_i, data_rvalid_i, data_we_o, data_err_i;
  logic [3:0] data_be_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;

  integer seed;
  int     cycle_cnt = 0;
  int     mismatch_cnt;
  int     fail_cnt;

  // Model state per port
  // Index 0 instruction and 1 data
  // Payloads kept as {addr, we, be, wdata}
  // Fetch uses addr only
  logic        c_pend [2];
  logic [68:0] c_pay [2];
  logic        m_hold [2];
  logic [68:0] m_pay [2];
  int          m_cnt [2];
  logic        m_rv [2];
  logic [31:0] m_rdata [2];
  logic        m_err [2];
  logic        m_fe;
  logic        m_pend;
  logic        m_sleep;

  // Memory side count of granted, unanswered transactions
  int          mem_cnt [2];

  core_bus_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Watchdog on the clock
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check(input string name, input logic [68:0] exp, input logic [68:0] act);
    if (exp !== act) begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One cycle of checks, stimulus and model update
  ////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic quiet);
    logic [68:0] bus_pay [2];
    logic        bus_req [2];
    logic        core_rdy [2];
    logic        core_rv [2];
    logic [31:0] core_rdata [2];
    logic        core_err [2];
    logic        acc [2];
    logic        gnt [2];
    logic        rv [2];
    logic        busy [2];
    logic [31:0] rdata [2];
    logic        err [2];
    logic        wake;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    string       bname;
    string       cname;
    int          p;

    // Outputs here come from registers only
    bus_req[0]    = instr_req_o;
    bus_req[1]    = data_req_o;
    bus_pay[0]    = {instr_addr_o, 37'd0};
    bus_pay[1]    = {data_addr_o, data_we_o, data_be_o, data_wdata_o};
    core_rdy[0]   = if_ready_o;
    core_rdy[1]   = lsu_ready_o;
    core_rv[0]    = if_rvalid_o;
    core_rv[1]    = lsu_rvalid_o;
    core_rdata[0] = if_rdata_o;
    core_rdata[1] = lsu_rdata_o;
    core_err[0]   = if_err_o;
    core_err[1]   = lsu_err_o;

    for (p = 0; p < 2; p++) begin
      bname = (p == 0) ? "instr" : "data";
      cname = (p == 0) ? "if" : "lsu";
      check({bname, "_req_o"}, 69'(m_hold[p]), 69'(bus_req[p]));
      // Oldest accepted request must be on the bus
      if (m_hold[p]) begin
        check({bname, "_payload"}, m_pay[p], bus_pay[p]);
      end
      check({cname, "_ready_o"}, 69'(!m_hold[p] && m_cnt[p] < MAX_OUT), 69'(core_rdy[p]));
      if (bus_req[p] && core_rdy[p]) begin
        fail_cnt++;
        $display("Error: %s_ready_o high while a request waits for grant", cname);
      end
      check({cname, "_rvalid_o"}, 69'(m_rv[p]), 69'(core_rv[p]));
      if (m_rv[p]) begin
        check({cname, "_rdata_o"}, 69'(m_rdata[p]), 69'(core_rdata[p]));
        check({cname, "_err_o"}, 69'(m_err[p]), 69'(core_err[p]));
      end
    end
    check("core_sleep_o", 69'(m_sleep), 69'(core_sleep_o));
    check("fetch_enable_o", 69'(m_fe), 69'(fetch_enable_o));

    // Core requests held until accepted
    // Memory grants the bus req late and answers late
    for (p = 0; p < 2; p++) begin
      r = $random(seed);
      a = $random(seed);
      d = $random(seed);
      if (!c_pend[p] && !quiet && r[2:0] == 3'd0) begin
        c_pend[p] = 1'b1;
        c_pay[p]  = (p == 0) ? {a, 37'd0} : {a, r[3], r[7:4], d};
      end
      acc[p]   = c_pend[p] && !m_hold[p] && (m_cnt[p] < MAX_OUT);
      gnt[p]   = bus_req[p] && r[8];
      // Never answer with nothing outstanding
      rv[p]    = (mem_cnt[p] > 0) && r[9];
      rdata[p] = $random(seed);
      err[p]   = (r[11:10] == 2'd0);
      busy[p]  = m_hold[p] || (m_cnt[p] != 0);
    end
    if_req_i       = c_pend[0];
    if_addr_i      = c_pay[0][68:37];
    lsu_req_i      = c_pend[1];
    lsu_addr_i     = c_pay[1][68:37];
    lsu_we_i       = c_pay[1][36];
    lsu_be_i       = c_pay[1][35:32];
    lsu_wdata_i    = c_pay[1][31:0];
    instr_gnt_i    = gnt[0];
    instr_rvalid_i = rv[0];
    instr_rdata_i  = rdata[0];
    instr_err_i    = err[0];
    data_gnt_i     = gnt[1];
    data_rvalid_i  = rv[1];
    data_rdata_i   = rdata[1];
    data_err_i     = err[1];

    // Interrupt mask is a random hit, a nonzero miss or zero
    r              = $random(seed);
    a              = $random(seed);
    wfi_i          = (r[3:0] == 4'd0);
    irq_i          = $random(seed);
    mie_i          = (r[5:4] == 2'd0) ? a : (r[5:4] == 2'd1) ? ~irq_i : 32'd0;
    fetch_enable_i = (cycle_cnt > 20) && r[6] && r[7];

    // Sleep uses the pending flag and busy levels before this edge
    wake    = |(irq_i & mie_i);
    m_sleep = m_pend && !busy[0] && !busy[1] && !wake;
    m_pend  = wake ? 1'b0 : (wfi_i ? 1'b1 : m_pend);
    m_fe    = m_fe || fetch_enable_i;
    for (p = 0; p < 2; p++) begin
      m_rv[p]    = rv[p];
      m_rdata[p] = rdata[p];
      m_err[p]   = err[p];
      mem_cnt[p] = mem_cnt[p] + int'(gnt[p]) - int'(rv[p]);
      if (mem_cnt[p] > MAX_OUT) begin
        fail_cnt++;
        $display("Error: port %0d has %0d outstanding, above the limit", p, mem_cnt[p]);
      end
      m_cnt[p]   = m_cnt[p] + int'(m_hold[p] && gnt[p]) - int'(rv[p]);
      if (acc[p]) begin
        m_hold[p] = 1'b1;
        m_pay[p]  = c_pay[p];
        c_pend[p] = 1'b0;
      end else if (gnt[p]) begin
        m_hold[p] = 1'b0;
      end
    end
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed           = 32'h39337e97;
    mismatch_cnt   = 0;
    fail_cnt       = 0;
    rst_i          = 1'b1;
    fetch_enable_i = 1'b0;
    wfi_i          = 1'b0;
    irq_i          = 32'd0;
    mie_i          = 32'd0;
    if_req_i       = 1'b0;
    if_addr_i      = 32'd0;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_be_i       = 4'd0;
    lsu_addr_i     = 32'd0;
    lsu_wdata_i    = 32'd0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'd0;
    instr_err_i    = 1'b0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = 32'd0;
    data_err_i     = 1'b0;
    m_fe           = 1'b0;
    m_pend         = 1'b0;
    m_sleep        = 1'b0;
    for (int p = 0; p < 2; p++) begin
      c_pend[p]  = 1'b0;
      c_pay[p]   = '0;
      m_hold[p]  = 1'b0;
      m_pay[p]   = '0;
      m_cnt[p]   = 0;
      m_rv[p]    = 1'b0;
      m_rdata[p] = 32'd0;
      m_err[p]   = 1'b0;
      mem_cnt[p] = 0;
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    repeat (STIM_CYCLES) run_cycle(1'b0);
    // Drain both ports
    while (c_pend[0] || c_pend[1] || m_hold[0] || m_hold[1] ||
           mem_cnt[0] != 0 || mem_cnt[1] != 0) begin
      run_cycle(1'b1);
    end
    // Last responses reach the core side
    repeat (4) run_cycle(1'b1);

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/core_bus_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bus_port_config.svh"

module core_bus_top (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Control and interrupts
  input  logic                   fetch_enable_i,
  input  logic                   wfi_i,
  input  logic [`BUS_DATA_W-1:0] irq_i,
  input  logic [`BUS_DATA_W-1:0] mie_i,

  // Instruction fetch, core side
  input  logic                   if_req_i,
  input  logic [`BUS_ADDR_W-1:0] if_addr_i,
  output logic                   if_ready_o,
  output logic                   if_rvalid_o,
  output logic [`BUS_DATA_W-1:0] if_rdata_o,
  output logic                   if_err_o,

  // Load store, core side
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  logic [`BUS_BE_W-1:0]   lsu_be_i,
  input  logic [`BUS_ADDR_W-1:0] lsu_addr_i,
  input  logic [`BUS_DATA_W-1:0] lsu_wdata_i,
  output logic                   lsu_ready_o,
  output logic                   lsu_rvalid_o,
  output logic [`BUS_DATA_W-1:0] lsu_rdata_o,
  output logic                   lsu_err_o,

  // Instruction memory bus
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  output logic [`BUS_ADDR_W-1:0] instr_addr_o,
  input  logic [`BUS_DATA_W-1:0] instr_rdata_i,
  input  logic                   instr_err_i,

  // Data memory bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic                   data_we_o,
  output logic [`BUS_BE_W-1:0]   data_be_o,
  output logic [`BUS_ADDR_W-1:0] data_addr_o,
  output logic [`BUS_DATA_W-1:0] data_wdata_o,
  input  logic [`BUS_DATA_W-1:0] data_rdata_i,
  input  logic                   data_err_i,

  // Status
  output logic                   fetch_enable_o,
  output logic                   core_sleep_o
);

  import bus_port_pkg::*;

  // Packed payloads, core side and bus side
  obi_instr_req_t if_payload;
  obi_instr_req_t instr_payload;
  obi_data_req_t  lsu_payload;
  obi_data_req_t  data_payload;

  // Responses, core side and bus side
  obi_resp_t      if_resp;
  obi_resp_t      instr_resp;
  obi_resp_t      lsu_resp;
  obi_resp_t      data_resp;

  // Port activity
  logic           if_busy;
  logic           lsu_busy;

  ////////////////////////////////////////////////////////////
  // Instruction port
  ////////////////////////////////////////////////////////////

  assign if_payload.addr  = if_addr_i;
  assign instr_addr_o     = instr_payload.addr;
  assign instr_resp.rdata = instr_rdata_i;
  assign instr_resp.err   = instr_err_i;
  assign if_rdata_o       = if_resp.rdata;
  assign if_err_o         = if_resp.err;

  obi_port_tracker #(
    .REQ_T (obi_instr_req_t)
  ) instr_tracker_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .core_req_i     (if_req_i),
    .core_payload_i (if_payload),
    .core_ready_o   (if_ready_o),
    .core_rvalid_o  (if_rvalid_o),
    .core_resp_o    (if_resp),
    .bus_req_o      (instr_req_o),
    .bus_payload_o  (instr_payload),
    .bus_gnt_i      (instr_gnt_i),
    .bus_rvalid_i   (instr_rvalid_i),
    .bus_resp_i     (instr_resp),
    .busy_o         (if_busy)
  );

  ////////////////////////////////////////////////////////////
  // Data port
  ////////////////////////////////////////////////////////////

  // Loose core fields into the request struct
  assign lsu_payload.addr  = lsu_addr_i;
  assign lsu_payload.we    = lsu_we_i;
  assign lsu_payload.be    = lsu_be_i;
  assign lsu_payload.wdata = lsu_wdata_i;

  // and back out onto the bus
  assign data_addr_o       = data_payload.addr;
  assign data_we_o         = data_payload.we;
  assign data_be_o         = data_payload.be;
  assign data_wdata_o      = data_payload.wdata;

  assign data_resp.rdata   = data_rdata_i;
  assign data_resp.err     = data_err_i;
  assign lsu_rdata_o       = lsu_resp.rdata;
  assign lsu_err_o         = lsu_resp.err;

  obi_port_tracker #(
    .REQ_T (obi_data_req_t)
  ) data_tracker_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .core_req_i     (lsu_req_i),
    .core_payload_i (lsu_payload),
    .core_ready_o   (lsu_ready_o),
    .core_rvalid_o  (lsu_rvalid_o),
    .core_resp_o    (lsu_resp),
    .bus_req_o      (data_req_o),
    .bus_payload_o  (data_payload),
    .bus_gnt_i      (data_gnt_i),
    .bus_rvalid_i   (data_rvalid_i),
    .bus_resp_i     (data_resp),
    .busy_o         (lsu_busy)
  );

  ////////////////////////////////////////////////////////////
  // Sleep
  ////////////////////////////////////////////////////////////

  // Both busy levels gate sleep entry
  sleep_unit sleep_unit_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .fetch_enable_o (fetch_enable_o),
    .wfi_i          (wfi_i),
    .irq_i          (irq_i),
    .mie_i          (mie_i),
    .if_busy_i      (if_busy),
    .lsu_busy_i     (lsu_busy),
    .core_sleep_o   (core_sleep_o)
  );

endmodule

`default_nettype wire

// ==== hdl/sleep_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bus_port_config.svh"

module sleep_unit (
  input  logic                   clk_i,
  input  logic                   rst_i,

  // Fetch enable from the system
  input  logic                   fetch_enable_i,
  output logic                   fetch_enable_o,

  // Wait for interrupt pulse
  input  logic                   wfi_i,

  // Interrupt lines and their enables
  input  logic [`BUS_DATA_W-1:0] irq_i,
  input  logic [`BUS_DATA_W-1:0] mie_i,

  // Port activity
  input  logic                   if_busy_i,
  input  logic                   lsu_busy_i,

  // Sleep status
  output logic                   core_sleep_o
);

  // One interrupt line per bit of a machine word
  localparam int IRQ_W = `BUS_DATA_W;

  // Latched fetch enable
  logic             fetch_enable_q;

  // Sleep state
  logic             sleep_pending_q;
  logic             core_sleep_q;
  logic             core_sleep_d;

  // Wake condition
  logic [IRQ_W-1:0] irq_masked;
  logic             wake;

  ////////////////////////////////////////////////////////////
  // Fetch enable
  ////////////////////////////////////////////////////////////

  // Sticky until reset, later toggles are ignored
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  assign fetch_enable_o = fetch_enable_q;

  ////////////////////////////////////////////////////////////
  // Sleep and wake
  ////////////////////////////////////////////////////////////

  // Any enabled interrupt pending
  assign irq_masked = irq_i & mie_i;
  assign wake       = |irq_masked;

  // Wake wins over a wfi in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sleep_pending_q <= 1'b0;
    end else if (wake) begin
      sleep_pending_q <= 1'b0;
    end else if (wfi_i) begin
      sleep_pending_q <= 1'b1;
    end
  end

  // Sleep only with both ports drained
  assign core_sleep_d = sleep_pending_q && !if_busy_i && !lsu_busy_i && !wake;

  // re-evaluated every cycle, so activity also drops it
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      core_sleep_q <= 1'b0;
    end else begin
      core_sleep_q <= core_sleep_d;
    end
  end

  assign core_sleep_o = core_sleep_q;

endmodule

`default_nettype wire

// ==== hdl/obi_port_tracker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "bus_port_config.svh"

module obi_port_tracker #(
  // Payload type of the request, instruction or data
  parameter type REQ_T = bus_port_pkg::obi_instr_req_t
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Core side request
  input  logic                    core_req_i,
  input  REQ_T                    core_payload_i,
  output logic                    core_ready_o,

  // Core side response
  output logic                    core_rvalid_o,
  output bus_port_pkg::obi_resp_t core_resp_o,

  // Bus side request
  output logic                    bus_req_o,
  output REQ_T                    bus_payload_o,
  input  logic                    bus_gnt_i,

  // Bus side response
  input  logic                    bus_rvalid_i,
  input  bus_port_pkg::obi_resp_t bus_resp_i,

  // Port activity for the sleep logic
  output logic                    busy_o
);

  import bus_port_pkg::*;

  // Outstanding limit as a counter value
  localparam logic [`BUS_CNT_W-1:0] MAX_CNT  = `BUS_CNT_W'(`BUS_MAX_OUTSTANDING);
  localparam logic [`BUS_CNT_W-1:0] CNT_STEP = `BUS_CNT_W'(1);

  // Held request
  logic                  hold_valid_q;
  REQ_T                  hold_payload_q;

  // Outstanding count
  logic [`BUS_CNT_W-1:0] out_cnt_q;
  logic [`BUS_CNT_W-1:0] out_cnt_d;

  // Handshake events
  logic                  accept;
  logic                  grant;

  // Registered response
  logic                  resp_valid_q;
  obi_resp_t             resp_q;

  ////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////

  // Room for one more only when nothing is held
  // and the count is below the limit
  assign core_ready_o = !hold_valid_q && (out_cnt_q < MAX_CNT);
  assign accept       = core_req_i && core_ready_o;

  // Grant only counts while req is up
  assign grant = hold_valid_q && bus_gnt_i;

  // req rises the cycle after accept, falls the cycle after gnt
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hold_valid_q <= 1'b0;
    end else if (accept) begin
      hold_valid_q <= 1'b1;
    end else if (grant) begin
      hold_valid_q <= 1'b0;
    end
  end

  // Payload stays stable until gnt
  // accept cannot happen while a request is held
  always_ff @(posedge clk_i) begin
    if (accept) begin
      hold_payload_q <= core_payload_i;
    end
  end

  assign bus_req_o     = hold_valid_q;
  assign bus_payload_o = hold_payload_q;

  ////////////////////////////////////////////////////////////
  // Outstanding counter
  ////////////////////////////////////////////////////////////

  // Up on gnt, down on rvalid, both at once leaves it alone
  always_comb begin
    out_cnt_d = out_cnt_q;
    if (grant && !bus_rvalid_i) begin
      out_cnt_d = out_cnt_q + CNT_STEP;
    end else if (!grant && bus_rvalid_i) begin
      out_cnt_d = out_cnt_q - CNT_STEP;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_cnt_q <= '0;
    end else begin
      out_cnt_q <= out_cnt_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////

  // One cycle from bus rvalid to core rvalid
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= bus_rvalid_i;
    end
  end

  // Data and err captured with the pulse
  always_ff @(posedge clk_i) begin
    if (bus_rvalid_i) begin
      resp_q <= bus_resp_i;
    end
  end

  assign core_rvalid_o = resp_valid_q;
  assign core_resp_o   = resp_q;

  // Waiting for gnt counts as busy too
  assign busy_o = hold_valid_q || (out_cnt_q != '0);

endmodule

`default_nettype wire

// ==== hdl/bus_port_pkg.sv ====
`default_nettype none

`include "bus_port_config.svh"

package bus_port_pkg;

  ////////////////////////////////////////////////////////////
  // Request payloads
  ////////////////////////////////////////////////////////////

  // Instruction fetch request
  // Address only, fetches are always full words
  typedef struct packed {
    logic [`BUS_ADDR_W-1:0] addr;
  } obi_instr_req_t;

  // Data request
  // Reads ignore be and wdata on the bus
  typedef struct packed {
    logic [`BUS_ADDR_W-1:0] addr;
    logic                   we;
    logic [`BUS_BE_W-1:0]   be;
    logic [`BUS_DATA_W-1:0] wdata;
  } obi_data_req_t;

  ////////////////////////////////////////////////////////////
  // Response payload
  ////////////////////////////////////////////////////////////

  // Shared by both ports
  // err set on a bus fault for the oldest outstanding transaction
  typedef struct packed {
    logic [`BUS_DATA_W-1:0] rdata;
    logic                   err;
  } obi_resp_t;

endpackage

`default_nettype wire

// ==== hdl/bus_port_config.svh ====
`ifndef BUS_PORT_CONFIG_SVH
`define BUS_PORT_CONFIG_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

// Word address on both ports
`define BUS_ADDR_W 32
// Read and write data
`define BUS_DATA_W 32
// One enable per byte lane
`define BUS_BE_W 4

////////////////////////////////////////////////////////////
// Outstanding transactions
////////////////////////////////////////////////////////////

// Granted but not yet answered, per port
`define BUS_MAX_OUTSTANDING 2
// Counter must hold BUS_MAX_OUTSTANDING itself
`define BUS_CNT_W 2

`endif
